// File: branch_predictor.f
bp_pkg.sv
sweep_counter.sv
table_clear_fsm.sv
local_hist_predictor.sv
gshare_predictor.sv
choice_table.sv
branch_predictor.sv
branch_predictor_tb.sv

// File: branch_predictor_tb.sv
`timescale 1ns/10ps

module branch_predictor_tb;

    import bp_pkg::*;

    logic                 clk;
    logic                 reset;
    logic [ADDR_BITS-1:0] fetch_pc;
    logic                 upd_valid;
    logic [ADDR_BITS-1:0] upd_pc;
    logic                 upd_taken;
    logic                 pred_taken;
    logic                 ready;

    // reference copies of the three tables
    logic [LOCAL_HIST_BITS-1:0]  m_hist   [LOCAL_PC_ENTRIES];
    logic [1:0]                  m_local  [LOCAL_CTR_ENTRIES];
    logic [GLOBAL_HIST_BITS-1:0] m_ghist;
    logic [1:0]                  m_gshare [GSHARE_ENTRIES];
    logic [1:0]                  m_choice [CHOICE_ENTRIES];

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          disagreements;

    branch_predictor uut (
        .clk        (clk),
        .reset      (reset),
        .fetch_pc   (fetch_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .pred_taken (pred_taken),
        .ready      (ready)
    );

    always #20 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic random_pc(output logic [ADDR_BITS-1:0] pc);
        logic [31:0] v;
        draw(10, v);
        pc = {20'h0, v[9:0], 2'b00};  // small range so entries get reused
    endtask

    function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
        logic [1:0] n;
        n = c;
        if (up && c != 2'd3) begin
            n = c + 2'd1;
        end else if (!up && c != 2'd0) begin
            n = c - 2'd1;
        end
        return n;
    endfunction

    function automatic logic [LOCAL_CTR_BITS-1:0] local_index(input logic [ADDR_BITS-1:0] pc);
        logic [LOCAL_PC_BITS-1:0] hi;
        hi = pc[LOCAL_PC_BITS+1:2];
        return {m_hist[hi], hi};
    endfunction

    function automatic logic [GLOBAL_HIST_BITS-1:0] gshare_index(input logic [ADDR_BITS-1:0] pc);
        return m_ghist ^ pc[GLOBAL_HIST_BITS+1:2];
    endfunction

    function automatic logic [CHOICE_PC_BITS-1:0] choice_index(input logic [ADDR_BITS-1:0] pc);
        return pc[CHOICE_PC_BITS+1:2];
    endfunction

    function automatic logic model_local(input logic [ADDR_BITS-1:0] pc);
        return m_local[local_index(pc)][1];
    endfunction

    function automatic logic model_gshare(input logic [ADDR_BITS-1:0] pc);
        return m_gshare[gshare_index(pc)][1];
    endfunction

    function automatic logic model_pred(input logic [ADDR_BITS-1:0] pc);
        return m_choice[choice_index(pc)][1] ? model_gshare(pc) : model_local(pc);
    endfunction

    task automatic model_clear;
        int i;
        for (i = 0; i < LOCAL_PC_ENTRIES; i++) begin
            m_hist[i] = '0;
        end
        for (i = 0; i < LOCAL_CTR_ENTRIES; i++) begin
            m_local[i] = 2'd0;
        end
        for (i = 0; i < GSHARE_ENTRIES; i++) begin
            m_gshare[i] = 2'd0;
        end
        for (i = 0; i < CHOICE_ENTRIES; i++) begin
            m_choice[i] = 2'd0;
        end
        m_ghist = '0;
    endtask

    task automatic model_update(input logic [ADDR_BITS-1:0] pc, input logic taken);
        logic [LOCAL_PC_BITS-1:0]    hi;
        logic [LOCAL_CTR_BITS-1:0]   li;
        logic [GLOBAL_HIST_BITS-1:0] gi;
        logic [CHOICE_PC_BITS-1:0]   ci;
        logic                        lp;
        logic                        gp;
        hi = pc[LOCAL_PC_BITS+1:2];
        li = local_index(pc);
        gi = gshare_index(pc);
        ci = choice_index(pc);
        lp = m_local[li][1];
        gp = m_gshare[gi][1];
        m_local[li]  = saturate(m_local[li], taken);
        m_gshare[gi] = saturate(m_gshare[gi], taken);
        if (lp != gp) begin
            disagreements++;
            m_choice[ci] = saturate(m_choice[ci], gp == taken);  // toward the winner
        end
        m_hist[hi] = {m_hist[hi][LOCAL_HIST_BITS-2:0], taken};
        m_ghist    = {m_ghist[GLOBAL_HIST_BITS-2:0], taken};
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        assert (act == exp) else begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic finish_run;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // one cycle: drive, check at negedge, then mirror the pending update
    task automatic apply(input string name, input logic [ADDR_BITS-1:0] pc, input logic valid,
                         input logic [ADDR_BITS-1:0] upc, input logic taken);
        @(posedge clk);
        fetch_pc  <= pc;
        upd_valid <= valid;
        upd_pc    <= upc;
        upd_taken <= taken;
        @(negedge clk);
        check_bit({name, " ready"}, 1'b1, ready);
        check_bit(name, model_pred(fetch_pc), pred_taken);
        if (upd_valid) begin
            model_update(upd_pc, upd_taken);
        end
    endtask

    task automatic reset_and_sweep(input string name);
        int          i;
        int          edges;
        logic [31:0] v;
        @(posedge clk);
        reset     <= 1'b1;
        upd_valid <= 1'b0;
        for (i = 1; i <= 10; i++) begin
            @(posedge clk);
            if (i == 10) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            check_bit({name, " ready in reset"}, 1'b0, ready);
            check_bit({name, " pred in reset"}, 1'b0, pred_taken);
        end
        edges = 0;
        while (!ready && edges < 2000) begin
            @(posedge clk);
            draw(10, v);
            fetch_pc  <= {20'h0, v[9:0], 2'b00};
            draw(10, v);
            upd_pc    <= {20'h0, v[9:0], 2'b00};
            draw(1, v);
            upd_valid <= v[0];  // strobes must be ignored while clearing
            draw(1, v);
            upd_taken <= v[0];
            edges++;
            @(negedge clk);
            if (!ready) begin
                check_bit({name, " pred during sweep"}, 1'b0, pred_taken);
            end
        end
        if (!ready) begin
            errors++;
            $display("%s: ready never rose within 2000 cycles", name);
            finish_run();
        end else begin
            check_count({name, " edges to ready"}, 1025, edges);
            model_clear();
            if (upd_valid) begin
                model_update(upd_pc, upd_taken);  // first strobe seen with ready high
            end
        end
    endtask

    task automatic check_all_not_taken(input string name);
        int i;
        for (i = 0; i < 1024; i++) begin
            apply(name, {20'h0, i[9:0], 2'b00}, 1'b0, '0, 1'b0);
            check_bit({name, " not taken"}, 1'b0, pred_taken);
        end
    endtask

    task automatic always_taken_test;
        int                   i;
        logic [ADDR_BITS-1:0] pc;
        pc = 32'h0000_0040;
        for (i = 0; i < 10; i++) begin
            apply("always taken", pc, 1'b1, pc, 1'b1);
        end
        apply("always taken", pc, 1'b0, '0, 1'b0);
        check_bit("always taken settled", 1'b1, pred_taken);  // local counter saturated
    endtask

    task automatic alternating_test;
        int                   i;
        logic [31:0]          v;
        logic [ADDR_BITS-1:0] pc_b;
        logic [ADDR_BITS-1:0] pc_c;
        pc_b = 32'h0000_0084;
        pc_c = 32'h0000_0118;  // other local history slot
        for (i = 0; i < 40; i++) begin
            apply("alternating", pc_b, 1'b1, pc_b, i[0]);
            if (i >= 16) begin
                check_bit("alternating local", i[0], uut.local_pred);
            end
            draw(1, v);
            apply("alternating", pc_b, 1'b1, pc_c, v[0]);
        end
    endtask

    task automatic choice_test;
        int                   i;
        logic [31:0]          v;
        logic [ADDR_BITS-1:0] pc_d;
        logic [ADDR_BITS-1:0] pc_o;
        logic                 exp_sel;
        pc_d          = 32'h0000_0200;
        disagreements = 0;
        for (i = 0; i < 64; i++) begin
            draw(1, v);
            exp_sel = m_choice[choice_index(pc_d)][1];  // selector before this update
            apply("choice training", pc_d, 1'b1, pc_d, v[0]);
            check_bit("choice selector", exp_sel, uut.use_gshare);
            random_pc(pc_o);
            draw(1, v);
            apply("choice training", pc_o, 1'b1, pc_o, v[0]);
        end
        checks++;
        assert (disagreements > 0) else begin
            errors++;
            $display("choice training: no update saw local and gshare disagree");
        end
        apply("choice final", pc_d, 1'b0, '0, 1'b0);
        check_bit("choice final component",
                  m_choice[choice_index(pc_d)][1] ? model_gshare(pc_d) : model_local(pc_d),
                  pred_taken);
    endtask

    task automatic random_stream_test;
        int                   i;
        logic [31:0]          v;
        logic [31:0]          sel;
        logic [ADDR_BITS-1:0] pc;
        logic [ADDR_BITS-1:0] upc;
        for (i = 0; i < 400; i++) begin
            random_pc(pc);
            draw(2, sel);
            if (sel[1:0] == 2'b00) begin
                upc = pc;  // lookup and update on the same branch
            end else begin
                random_pc(upc);
            end
            draw(1, v);
            draw(1, sel);
            apply("random stream", pc, v[0], upc, sel[0]);
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        fetch_pc      = '0;
        upd_valid     = 1'b0;
        upd_pc        = '0;
        upd_taken     = 1'b0;
        lfsr          = 32'h99b1_95ba;
        checks        = 0;
        errors        = 0;
        disagreements = 0;
        model_clear();
        reset_and_sweep("power-on clear");
        check_all_not_taken("cleared table");
        always_taken_test();
        alternating_test();
        choice_test();
        random_stream_test();
        reset_and_sweep("reset mid run");
        check_all_not_taken("cleared after reset");
        finish_run();
    end

endmodule

// File: branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [bp_pkg::ADDR_BITS-1:0] fetch_pc,
    input  logic                         upd_valid,
    input  logic [bp_pkg::ADDR_BITS-1:0] upd_pc,
    input  logic                         upd_taken,
    output logic                         pred_taken,
    output logic                         ready
);

    import bp_pkg::*;

    logic [CLEAR_INDEX_BITS-1:0] clear_index;
    logic                        clear_last;
    logic                        clear_en;
    logic                        table_upd_valid;
    logic                        local_pred;
    logic                        local_upd_pred;
    logic                        gshare_pred;
    logic                        gshare_upd_pred;
    logic                        use_gshare;

    assign table_upd_valid = upd_valid & ready;  // no training before clear ends

    sweep_counter u_sweep_counter (
        .clk         (clk),
        .reset       (reset),
        .clear_en    (clear_en),
        .clear_index (clear_index),
        .clear_last  (clear_last)
    );

    table_clear_fsm u_table_clear_fsm (
        .clk        (clk),
        .reset      (reset),
        .clear_last (clear_last),
        .clear_en   (clear_en),
        .ready      (ready)
    );

    local_hist_predictor u_local (
        .clk         (clk),
        .clear_en    (clear_en),
        .clear_index (clear_index),
        .fetch_pc    (fetch_pc),
        .upd_valid   (table_upd_valid),
        .upd_pc      (upd_pc),
        .upd_taken   (upd_taken),
        .pred_taken  (local_pred),
        .upd_pred    (local_upd_pred)
    );

    gshare_predictor u_gshare (
        .clk         (clk),
        .clear_en    (clear_en),
        .clear_index (clear_index),
        .fetch_pc    (fetch_pc),
        .upd_valid   (table_upd_valid),
        .upd_pc      (upd_pc),
        .upd_taken   (upd_taken),
        .pred_taken  (gshare_pred),
        .upd_pred    (gshare_upd_pred)
    );

    choice_table u_choice (
        .clk             (clk),
        .clear_en        (clear_en),
        .clear_index     (clear_index),
        .fetch_pc        (fetch_pc),
        .upd_valid       (table_upd_valid),
        .upd_pc          (upd_pc),
        .upd_taken       (upd_taken),
        .local_upd_pred  (local_upd_pred),
        .gshare_upd_pred (gshare_upd_pred),
        .use_gshare      (use_gshare)
    );

    assign pred_taken = ready & (use_gshare ? gshare_pred : local_pred);

endmodule

// File: choice_table.sv
`timescale 1ns/10ps

module choice_table (
    input  logic                                clk,
    input  logic                                clear_en,
    input  logic [bp_pkg::CLEAR_INDEX_BITS-1:0] clear_index,
    input  logic [bp_pkg::ADDR_BITS-1:0]        fetch_pc,
    input  logic                                upd_valid,
    input  logic [bp_pkg::ADDR_BITS-1:0]        upd_pc,
    input  logic                                upd_taken,
    input  logic                                local_upd_pred,
    input  logic                                gshare_upd_pred,
    output logic                                use_gshare
);

    import bp_pkg::*;

    logic [1:0]                selectors [CHOICE_ENTRIES];  // 0..1 local, 2..3 gshare

    logic [CHOICE_PC_BITS-1:0] ci;
    logic [CHOICE_PC_BITS-1:0] u_ci;
    logic [1:0]                u_sel;
    logic                      disagree;
    logic                      gshare_right;

    assign ci         = fetch_pc[CHOICE_PC_BITS+1:2];
    assign use_gshare = selectors[ci][1];

    assign u_ci  = upd_pc[CHOICE_PC_BITS+1:2];
    assign u_sel = selectors[u_ci];

    assign disagree     = local_upd_pred != gshare_upd_pred;
    assign gshare_right = gshare_upd_pred == upd_taken;

    // only a disagreement tells which side is better
    always_ff @(posedge clk) begin
        if (clear_en) begin
            selectors[clear_index[CHOICE_PC_BITS-1:0]] <= CTR_MIN;
        end else if (upd_valid && disagree) begin
            selectors[u_ci] <= sat_update(u_sel, gshare_right);
        end
    end

endmodule

// File: gshare_predictor.sv
`timescale 1ns/10ps

module gshare_predictor (
    input  logic                                clk,
    input  logic                                clear_en,
    input  logic [bp_pkg::CLEAR_INDEX_BITS-1:0] clear_index,
    input  logic [bp_pkg::ADDR_BITS-1:0]        fetch_pc,
    input  logic                                upd_valid,
    input  logic [bp_pkg::ADDR_BITS-1:0]        upd_pc,
    input  logic                                upd_taken,
    output logic                                pred_taken,
    output logic                                upd_pred
);

    import bp_pkg::*;

    logic [GLOBAL_HIST_BITS-1:0] ghist;
    logic [1:0]                  counters [GSHARE_ENTRIES];

    logic [GLOBAL_HIST_BITS-1:0] gidx;
    logic [GLOBAL_HIST_BITS-1:0] u_gidx;
    logic [1:0]                  count;
    logic [1:0]                  u_count;

    assign gidx  = ghist ^ fetch_pc[GLOBAL_HIST_BITS+1:2];
    assign count = counters[gidx];

    assign pred_taken = count[1];

    assign u_gidx  = ghist ^ upd_pc[GLOBAL_HIST_BITS+1:2];
    assign u_count = counters[u_gidx];

    assign upd_pred = u_count[1];

    // global history, shifted in on every retired branch
    always_ff @(posedge clk) begin
        if (clear_en) begin
            ghist <= '0;
        end else if (upd_valid) begin
            ghist <= {ghist[GLOBAL_HIST_BITS-2:0], upd_taken};
        end
    end

    always_ff @(posedge clk) begin
        if (clear_en) begin
            counters[clear_index[GLOBAL_HIST_BITS-1:0]] <= CTR_MIN;  // index mod 256
        end else if (upd_valid) begin
            counters[u_gidx] <= sat_update(u_count, upd_taken);
        end
    end

endmodule

// File: local_hist_predictor.sv
`timescale 1ns/10ps

module local_hist_predictor (
    input  logic                                clk,
    input  logic                                clear_en,
    input  logic [bp_pkg::CLEAR_INDEX_BITS-1:0] clear_index,
    input  logic [bp_pkg::ADDR_BITS-1:0]        fetch_pc,
    input  logic                                upd_valid,
    input  logic [bp_pkg::ADDR_BITS-1:0]        upd_pc,
    input  logic                                upd_taken,
    output logic                                pred_taken,
    output logic                                upd_pred
);

    import bp_pkg::*;

    logic [LOCAL_HIST_BITS-1:0] history  [LOCAL_PC_ENTRIES];   // pc -> history
    logic [1:0]                 counters [LOCAL_CTR_ENTRIES];  // history + pc -> counter

    logic [LOCAL_PC_BITS-1:0]   histi;
    logic [LOCAL_PC_BITS-1:0]   u_histi;
    logic [LOCAL_CTR_BITS-1:0]  phti;
    logic [LOCAL_CTR_BITS-1:0]  u_phti;
    logic [1:0]                 count;
    logic [1:0]                 u_count;

    // fetch side lookup
    assign histi = fetch_pc[LOCAL_PC_BITS+1:2];
    assign phti  = {history[histi], histi};
    assign count = counters[phti];

    assign pred_taken = count[1];

    // update side lookup, same path from upd_pc
    assign u_histi = upd_pc[LOCAL_PC_BITS+1:2];
    assign u_phti  = {history[u_histi], u_histi};
    assign u_count = counters[u_phti];

    assign upd_pred = u_count[1];

    always_ff @(posedge clk) begin
        if (clear_en) begin
            counters[clear_index[LOCAL_CTR_BITS-1:0]] <= CTR_MIN;
            history[clear_index[LOCAL_PC_BITS-1:0]]   <= '0;  // revisited, harmless
        end else if (upd_valid) begin
            counters[u_phti] <= sat_update(u_count, upd_taken);
            history[u_histi] <= {history[u_histi][LOCAL_HIST_BITS-2:0], upd_taken};
        end
    end

endmodule

// File: table_clear_fsm.sv
`timescale 1ns/10ps

module table_clear_fsm (
    input  logic clk,
    input  logic reset,
    input  logic clear_last,
    output logic clear_en,
    output logic ready
);

    import bp_pkg::*;

    clear_state_e state;
    clear_state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CLEAR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            CLEAR_IDLE: begin
                state_next = CLEAR_SWEEP;  // start sweep once out of reset
            end
            CLEAR_SWEEP: begin
                if (clear_last) begin
                    state_next = CLEAR_DONE;
                end
            end
            CLEAR_DONE: begin
                state_next = CLEAR_DONE;  // held until next reset
            end
            default: begin
                state_next = CLEAR_IDLE;
            end
        endcase
    end

    assign clear_en = (state == CLEAR_SWEEP);
    assign ready    = (state == CLEAR_DONE);

endmodule

// File: sweep_counter.sv
`timescale 1ns/10ps

module sweep_counter (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clear_en,
    output logic [bp_pkg::CLEAR_INDEX_BITS-1:0] clear_index,
    output logic                                clear_last
);

    always_ff @(posedge clk) begin
        if (reset) begin
            clear_index <= '0;
        end else if (clear_en) begin
            clear_index <= clear_index + 1'b1;  // wraps to zero after last
        end
    end

    assign clear_last = &clear_index;  // final table index

endmodule

// File: bp_pkg.sv
package bp_pkg;

    localparam int ADDR_BITS        = 32;
    localparam int LOCAL_PC_BITS    = 4;   // pc bits into local history table
    localparam int LOCAL_HIST_BITS  = 6;
    localparam int GLOBAL_HIST_BITS = 8;
    localparam int CLEAR_INDEX_BITS = 10;  // covers the largest table

    // derived table geometry
    localparam int LOCAL_PC_ENTRIES   = 2 ** LOCAL_PC_BITS;
    localparam int LOCAL_CTR_BITS     = LOCAL_HIST_BITS + LOCAL_PC_BITS;
    localparam int LOCAL_CTR_ENTRIES  = 2 ** LOCAL_CTR_BITS;
    localparam int GSHARE_ENTRIES     = 2 ** GLOBAL_HIST_BITS;
    localparam int CHOICE_PC_BITS     = GLOBAL_HIST_BITS;
    localparam int CHOICE_ENTRIES     = 2 ** CHOICE_PC_BITS;

    localparam logic [1:0] CTR_MAX = 2'b11;
    localparam logic [1:0] CTR_MIN = 2'b00;

    typedef enum logic [1:0] {
        CLEAR_IDLE,
        CLEAR_SWEEP,
        CLEAR_DONE
    } clear_state_e;

    // two-bit saturating step, up or down
    function automatic logic [1:0] sat_update(input logic [1:0] ctr, input logic up);
        logic [1:0] next_ctr;
        next_ctr = ctr;
        if (up) begin
            if (ctr != CTR_MAX) begin
                next_ctr = ctr + 2'd1;
            end
        end else begin
            if (ctr != CTR_MIN) begin
                next_ctr = ctr - 2'd1;
            end
        end
        return next_ctr;
    endfunction

endpackage
